// File: Bender.yml
package:
  name: servo_channel

sources:
  - files:
      - hw/lock_pkg.sv
      - hw/iir_stage.sv
      - hw/relock_sweep.sv
      - hw/lock_status.sv
      - hw/servo_channel.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_servo_channel.sv

// File: dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period_ns    = 10.0,
    parameter int  reset_cycles = 16
) (
    output logic clk_in,
    output logic arst_n
);

    // Free-running clock
    initial begin
        clk_in = 1'b0;
        forever #(period_ns / 2.0) clk_in = ~clk_in;
    end

    // Reset low for the first cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_servo_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_servo_channel;

    import lock_pkg::*;

    localparam int      timeout_cycles = 4000;
    // Fixed-point unity and one half
    localparam coef_t   unity          = coef_t'(1) << coef_frac_bits;
    localparam coef_t   half           = coef_t'(1) << (coef_frac_bits - 1);
    // Well above and well below the default minimum
    localparam sample_t trans_high     = 16'sh6000;
    localparam sample_t trans_low      = 16'sh0100;

    logic        clk_in;
    logic        arst_n;
    sample_t     trans_in;
    sample_t     err_in;
    logic        param_load;
    param_id_t   param_sel;
    coef_t       param_data;
    sample_t     signal_out;
    lock_state_t lock_state;
    // Sweep value while the servo holds lock
    sample_t     sweep_frozen;
    int          cycle_cnt = 0;

    tb_clock i_tb_clock (
        .clk_in (clk_in),
        .arst_n (arst_n)
    );

    servo_channel #(
        .hold_cycles (20)
    ) i_servo_channel (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .trans_in   (trans_in),
        .err_in     (err_in),
        .param_load (param_load),
        .param_sel  (param_sel),
        .param_data (param_data),
        .signal_out (signal_out),
        .lock_state (lock_state)
    );

    ////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t actual,
                                input sample_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_state(input string name, input lock_state_t actual,
                               input lock_state_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            report_failure();
        end
    endtask

    task automatic require(input bit cond, input string what);
        if (!cond) begin
            $display("Check failed, %s", what);
            report_failure();
        end
    endtask

    // Run aborts if the tests stall
    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("Timeout, tests did not finish within %0d cycles", timeout_cycles);
            report_failure();
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers and reference
    ////////////////////////////////////////

    // One-cycle load strobe
    task automatic load_param(input param_id_t id, input coef_t data);
        @(negedge clk_in);
        param_load = 1'b1;
        param_sel  = id;
        param_data = data;
        @(negedge clk_in);
        param_load = 1'b0;
    endtask

    // Level in the top 16 bits of a load word
    function automatic coef_t top_word(input sample_t level);
        return {level, 19'd0};
    endfunction

    // y = sat((a1*y_prev + b0*x + b1*x_prev) >>> frac bits)
    function automatic sample_t stage_rule(input coef_t a1, input coef_t b0, input coef_t b1,
                                           input sample_t y_prev, input sample_t x,
                                           input sample_t x_prev);
        acc_t sum;
        sum = acc_t'(a1) * acc_t'(y_prev) + acc_t'(b0) * acc_t'(x)
            + acc_t'(b1) * acc_t'(x_prev);
        sum = sum >>> coef_frac_bits;
        if (sum > acc_t'(sample_max)) begin
            return sample_max;
        end else if (sum < acc_t'(sample_min)) begin
            return sample_min;
        end else begin
            return sample_t'(sum);
        end
    endfunction

    // From locked, drop transmission and see the unlock one edge later
    task automatic enter_unlock(input sample_t level);
        @(negedge clk_in);
        trans_in = level;
        @(negedge clk_in);
        check_state("lock_state", lock_state, st_locked);
        @(negedge clk_in);
        check_state("lock_state", lock_state, st_unlocked);
    endtask

    // Restore transmission, then 20 cycles relocked and back to locked
    task automatic release_and_check_hold(input sample_t level, input bit check_freeze);
        sample_t frozen;
        @(negedge clk_in);
        trans_in = level;
        for (int i = 1; i <= 22; i++) begin
            @(negedge clk_in);
            if (i == 1) begin
                check_state("lock_state", lock_state, st_unlocked);
            end else if (i <= 21) begin
                check_state("lock_state", lock_state, st_relocked);
            end else begin
                check_state("lock_state", lock_state, st_locked);
            end
            // Sweep may take one last step before hold
            if (check_freeze && i == 3) frozen = signal_out;
            if (check_freeze && i > 3) check_sample("signal_out", signal_out, frozen);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        repeat (3) @(negedge clk_in);
        check_state("lock_state", lock_state, st_locked);
        check_sample("signal_out", signal_out, sweep_min_default);
    endtask

    task automatic test_pass_through();
        sample_t vals[50];
        load_param(pd_a1, '0);
        load_param(pd_b0, unity);
        load_param(pd_b1, '0);
        load_param(pi_a1, '0);
        load_param(pi_b0, unity);
        load_param(pi_b1, '0);
        foreach (vals[i]) vals[i] = sample_t'($urandom());
        // Three samples in flight, err_in to signal_out
        for (int i = 0; i < 53; i++) begin
            @(negedge clk_in);
            if (i >= 3) begin
                check_sample("signal_out", signal_out, sample_t'(sweep_frozen + vals[i-3]));
            end
            if (i < 50) begin
                err_in = vals[i];
            end else begin
                err_in = '0;
            end
        end
    endtask

    task automatic test_integrator();
        sample_t e;
        sample_t pd_y;
        sample_t pd_x;
        sample_t pi_y;
        sample_t pi_x;
        sample_t next_pd;
        sample_t next_pi;
        sample_t out_exp;
        load_param(pi_a1, unity);
        load_param(pi_b0, half);
        load_param(pi_b1, half);
        pd_y    = '0;
        pd_x    = '0;
        pi_y    = '0;
        pi_x    = '0;
        out_exp = sweep_frozen;
        for (int n = 0; n < 54; n++) begin
            @(negedge clk_in);
            check_sample("signal_out", signal_out, out_exp);
            // Small steps, then large ones into saturation
            case (n / 12)
                0: e = 16'sd3;
                1: e = -16'sd7;
                2: e = 16'sh3000;
                3: e = -16'sh3000;
                default: e = '0;
            endcase
            err_in = e;
            // One clock of the reference cascade
            next_pd = stage_rule('0, unity, '0, pd_y, e, pd_x);
            next_pi = stage_rule(unity, half, half, pi_y, pd_y, pi_x);
            out_exp = sample_t'(sweep_frozen + pi_y);
            pd_x    = e;
            pi_x    = pd_y;
            pd_y    = next_pd;
            pi_y    = next_pi;
        end
    endtask

    task automatic test_relock_sweep();
        sample_t lo;
        sample_t hi;
        sample_t prev;
        sample_t dir;
        int      since;
        int      changes;
        int      hits_hi;
        int      hits_lo;
        lo = sweep_min_default - 16'sd2;
        hi = sweep_min_default + 16'sd2;
        load_param(sweep_step, coef_t'(4) << 3);
        load_param(sweep_min, top_word(lo));
        load_param(sweep_max, top_word(hi));
        enter_unlock(trans_low);
        // Stages cleared, sweep not yet moved
        @(negedge clk_in);
        check_sample("signal_out", signal_out, sweep_frozen);
        prev    = sweep_frozen;
        dir     = 16'sd1;
        since   = 0;
        changes = 0;
        hits_hi = 0;
        hits_lo = 0;
        repeat (48) begin
            @(negedge clk_in);
            since++;
            if (signal_out !== prev) begin
                check_sample("signal_out", signal_out, sample_t'(prev + dir));
                require(changes == 0 || since == 4, "sweep step spacing is not 4 cycles");
                changes++;
                since = 0;
                prev  = signal_out;
                // Turnaround points
                if (prev == hi) begin
                    dir = -16'sd1;
                    hits_hi++;
                end
                if (prev == lo) begin
                    dir = 16'sd1;
                    hits_lo++;
                end
            end
        end
        require(hits_hi > 0 && hits_lo > 0, "sweep did not reverse at both limits");
        release_and_check_hold(trans_high, 1'b1);
    endtask

    task automatic test_relock_hold();
        enter_unlock(trans_low);
        repeat (4) begin
            @(negedge clk_in);
            check_state("lock_state", lock_state, st_unlocked);
        end
        release_and_check_hold(trans_high, 1'b0);
        // Dip below the minimum in the middle of the hold
        enter_unlock(trans_low);
        @(negedge clk_in);
        trans_in = trans_high;
        @(negedge clk_in);
        check_state("lock_state", lock_state, st_unlocked);
        repeat (8) begin
            @(negedge clk_in);
            check_state("lock_state", lock_state, st_relocked);
        end
        trans_in = trans_low;
        @(negedge clk_in);
        check_state("lock_state", lock_state, st_relocked);
        @(negedge clk_in);
        check_state("lock_state", lock_state, st_unlocked);
        release_and_check_hold(trans_high, 1'b0);
    endtask

    task automatic test_relock_min_load();
        load_param(relock_min, top_word(16'sh1000));
        enter_unlock(16'sh0fff);
        // At the new minimum counts as transmission
        release_and_check_hold(16'sh1000, 1'b0);
        repeat (10) begin
            @(negedge clk_in);
            check_state("lock_state", lock_state, st_locked);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int seed_val;
        trans_in     = trans_high;
        err_in       = '0;
        param_load   = 1'b0;
        param_sel    = pd_a1;
        param_data   = '0;
        sweep_frozen = sweep_min_default;
        seed_val     = $urandom(99746);
        @(posedge arst_n);
        test_reset_state();
        test_pass_through();
        test_integrator();
        test_relock_sweep();
        test_relock_hold();
        test_relock_min_load();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/lock_pkg.sv
hw/iir_stage.sv
hw/relock_sweep.sv
hw/lock_status.sv
hw/servo_channel.sv
dv/tb_clock.sv
dv/tb_servo_channel.sv

// File: hw/iir_stage.sv
`timescale 1ns/1ps
`default_nettype none

module iir_stage #(
    parameter lock_pkg::param_id_t base_id    = lock_pkg::pd_a1,
    parameter lock_pkg::coef_t     a1_default = '0,
    parameter lock_pkg::coef_t     b0_default = '0,
    parameter lock_pkg::coef_t     b1_default = '0
) (
    input  wire                  clk_in,
    input  wire                  arst_n,
    input  wire                  on,
    input  wire lock_pkg::sample_t x,
    input  wire                  param_load,
    input  wire lock_pkg::param_id_t param_sel,
    input  wire lock_pkg::coef_t param_data,
    output lock_pkg::sample_t    y
);

    import lock_pkg::*;

    // Three consecutive ids from base
    localparam param_id_t id_a1 = base_id;
    localparam param_id_t id_b0 = param_id_t'(base_id + 4'd1);
    localparam param_id_t id_b1 = param_id_t'(base_id + 4'd2);

    coef_t   a1;
    coef_t   b0;
    coef_t   b1;
    sample_t x_prev;
    acc_t    acc;
    acc_t    acc_shift;
    sample_t y_sat;

    // Coefficient registers, full word load
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            a1 <= a1_default;
            b0 <= b0_default;
            b1 <= b1_default;
        end else if (param_load) begin
            if (param_sel == id_a1) a1 <= param_data;
            if (param_sel == id_b0) b0 <= param_data;
            if (param_sel == id_b1) b1 <= param_data;
        end
    end

    // y[n] = a1*y[n-1] + b0*x[n] + b1*x[n-1]
    assign acc       = a1 * y + b0 * x + b1 * x_prev;
    assign acc_shift = acc >>> coef_frac_bits;

    // Clip to sample range
    always_comb begin
        if (acc_shift > acc_t'(sample_max)) begin
            y_sat = sample_max;
        end else if (acc_shift < acc_t'(sample_min)) begin
            y_sat = sample_min;
        end else begin
            y_sat = sample_t'(acc_shift);
        end
    end

    // Filter state, cleared while servo is off
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            y      <= '0;
            x_prev <= '0;
        end else if (!on) begin
            y      <= '0;
            x_prev <= '0;
        end else begin
            y      <= y_sat;
            x_prev <= x;
        end
    end

endmodule

`default_nettype wire

// File: hw/lock_pkg.sv
`default_nettype none

package lock_pkg;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    // ADC or DAC sample, two's complement
    typedef logic signed [15:0] sample_t;
    // Filter coefficient or load word
    typedef logic signed [34:0] coef_t;
    // Sweep period, clocks per output LSB
    typedef logic [31:0] step_t;
    // Product sum inside one stage
    typedef logic signed [51:0] acc_t;

    // Binary point of coef_t
    localparam int coef_frac_bits = 26;
    localparam sample_t sample_max = 16'h7fff;
    localparam sample_t sample_min = 16'h8000;

    // Run-time parameter select
    typedef enum logic [3:0] {
        pd_a1, pd_b0, pd_b1,
        pi_a1, pi_b0, pi_b1,
        relock_min,
        sweep_max, sweep_min, sweep_step
    } param_id_t;

    typedef enum logic [1:0] {
        st_locked,
        st_unlocked,
        st_relocked
    } lock_state_t;

    ////////////////////////////////////////
    // Servo design constants
    ////////////////////////////////////////

    localparam real servo_gain    = 0.5;
    localparam real pd_gain       = servo_gain * 0.06;
    localparam real pi_gain       = servo_gain * 1.0;
    localparam real int_gain      = servo_gain * 400.0;
    localparam real der_gain      = servo_gain * 0.7e-6;
    // Rolloff of the derivative term, Hz
    localparam real rolloff_hz    = 1.0e7;
    // 100 MHz sample clock
    localparam real sample_period = 1.0e-8;
    localparam real pi_val        = 3.14159265358979;
    localparam real coef_unity    = 2.0 ** coef_frac_bits;
    localparam real full_scale    = 32767.0;
    // Bilinear warp term pi*Ts*fc
    localparam real bilin_k       = pi_val * sample_period * rolloff_hz;

    // PD stage, derivative with first-order rolloff
    localparam coef_t pd_a1_default = (1.0 - 2.0 * bilin_k) * coef_unity;
    localparam coef_t pd_b0_default = ((der_gain / pi_gain) * (rolloff_hz / (1.0 + bilin_k))
        + pd_gain * (bilin_k / (1.0 + bilin_k))) * coef_unity;
    localparam coef_t pd_b1_default = (pd_gain * (bilin_k / (1.0 + bilin_k))
        - (der_gain / pi_gain) * (rolloff_hz / (1.0 + bilin_k))) * coef_unity;

    // PI stage, pure integrator pole
    localparam coef_t pi_a1_default = coef_unity;
    localparam coef_t pi_b0_default =
        (pi_gain + int_gain * pi_val * sample_period / pd_gain) * coef_unity;
    localparam coef_t pi_b1_default =
        (int_gain * pi_val * sample_period / pd_gain - pi_gain) * coef_unity;

    // Relock defaults, fractions of full scale
    localparam sample_t relock_min_default = 0.25 * full_scale;
    localparam sample_t sweep_max_default  = 0.65625 * full_scale;
    localparam sample_t sweep_min_default  = 0.1875 * full_scale;
    localparam step_t   sweep_step_default = 32'd128;

endpackage

`default_nettype wire

// File: hw/lock_status.sv
`timescale 1ns/1ps
`default_nettype none

module lock_status #(
    parameter int unsigned hold_cycles = 100_000_000
) (
    input  wire                    clk_in,
    input  wire                    arst_n,
    input  wire                    relock_on,
    output lock_pkg::lock_state_t  state
);

    import lock_pkg::*;

    // Wide enough to reach hold_cycles
    localparam int cnt_w = $clog2(hold_cycles + 1);

    lock_state_t      state_next;
    logic [cnt_w-1:0] hold_cnt;
    logic             hold_done;

    assign hold_done = (hold_cnt == cnt_w'(hold_cycles - 1));

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            st_locked: begin
                if (relock_on) state_next = st_unlocked;
            end
            st_unlocked: begin
                // Transmission back, start hold
                if (!relock_on) state_next = st_relocked;
            end
            st_relocked: begin
                if (relock_on) begin
                    state_next = st_unlocked;
                end else if (hold_done) begin
                    state_next = st_locked;
                end
            end
            default: state_next = st_locked;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_locked;
            hold_cnt <= '0;
        end else begin
            state <= state_next;
            // Counts only during the hold window
            if (state == st_relocked) hold_cnt <= hold_cnt + 1'b1;
            else hold_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/relock_sweep.sv
`timescale 1ns/1ps
`default_nettype none

module relock_sweep (
    input  wire                    clk_in,
    input  wire                    arst_n,
    input  wire                    hold,
    input  wire                    param_load,
    input  wire lock_pkg::param_id_t param_sel,
    input  wire lock_pkg::coef_t   param_data,
    output lock_pkg::sample_t      sweep_out
);

    import lock_pkg::*;

    sample_t sweep_min_r;
    sample_t sweep_max_r;
    step_t   step_r;
    step_t   cnt;
    step_t   cnt_next;
    logic    step_done;
    // High while sweeping toward max
    logic    dir_up;

    ////////////////////////////////////////
    // Sweep settings
    ////////////////////////////////////////

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            sweep_min_r <= sweep_min_default;
            sweep_max_r <= sweep_max_default;
            step_r      <= sweep_step_default;
        end else if (param_load) begin
            // Limits from top of load word
            if (param_sel == sweep_max) sweep_max_r <= param_data[34:19];
            if (param_sel == sweep_min) sweep_min_r <= param_data[34:19];
            if (param_sel == sweep_step) step_r <= param_data[34:3];
        end
    end

    ////////////////////////////////////////
    // Step timer and triangle
    ////////////////////////////////////////

    assign cnt_next  = cnt + step_t'(1);
    // Also fires when step shrinks below count
    assign step_done = (cnt_next >= step_r);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= '0;
            dir_up    <= 1'b1;
            sweep_out <= sweep_min_default;
        end else if (!hold) begin
            if (step_done) begin
                cnt <= '0;
                // Turn around at either limit
                if (dir_up && (sweep_out >= sweep_max_r)) begin
                    dir_up    <= 1'b0;
                    sweep_out <= sweep_out - sample_t'(1);
                end else if (!dir_up && (sweep_out <= sweep_min_r)) begin
                    dir_up    <= 1'b1;
                    sweep_out <= sweep_out + sample_t'(1);
                end else if (dir_up) begin
                    sweep_out <= sweep_out + sample_t'(1);
                end else begin
                    sweep_out <= sweep_out - sample_t'(1);
                end
            end else begin
                cnt <= cnt_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/servo_channel.sv
`timescale 1ns/1ps
`default_nettype none

module servo_channel #(
    parameter int unsigned hold_cycles = 100_000_000
) (
    input  wire                      clk_in,
    input  wire                      arst_n,
    input  wire lock_pkg::sample_t   trans_in,
    input  wire lock_pkg::sample_t   err_in,
    input  wire                      param_load,
    input  wire lock_pkg::param_id_t param_sel,
    input  wire lock_pkg::coef_t     param_data,
    output lock_pkg::sample_t        signal_out,
    output lock_pkg::lock_state_t    lock_state
);

    import lock_pkg::*;

    sample_t relock_min_r;
    logic    relock_on;
    logic    servo_on;
    sample_t pd_y;
    sample_t pi_y;
    sample_t sweep_val;

    ////////////////////////////////////////
    // Relock detect
    ////////////////////////////////////////

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            relock_min_r <= relock_min_default;
            relock_on    <= 1'b0;
        end else begin
            // Level from top 16 bits of word
            if (param_load && (param_sel == relock_min)) relock_min_r <= param_data[34:19];
            relock_on <= (trans_in < relock_min_r);
        end
    end

    // Servo runs only with enough transmission
    assign servo_on = ~relock_on;

    ////////////////////////////////////////
    // Servo cascade, PD then PI
    ////////////////////////////////////////

    iir_stage #(
        .base_id    (pd_a1),
        .a1_default (pd_a1_default),
        .b0_default (pd_b0_default),
        .b1_default (pd_b1_default)
    ) i_pd_stage (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .on         (servo_on),
        .x          (err_in),
        .param_load (param_load),
        .param_sel  (param_sel),
        .param_data (param_data),
        .y          (pd_y)
    );

    iir_stage #(
        .base_id    (pi_a1),
        .a1_default (pi_a1_default),
        .b0_default (pi_b0_default),
        .b1_default (pi_b1_default)
    ) i_pi_stage (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .on         (servo_on),
        .x          (pd_y),
        .param_load (param_load),
        .param_sel  (param_sel),
        .param_data (param_data),
        .y          (pi_y)
    );

    // Sweep frozen while servo holds lock
    relock_sweep i_relock_sweep (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .hold       (servo_on),
        .param_load (param_load),
        .param_sel  (param_sel),
        .param_data (param_data),
        .sweep_out  (sweep_val)
    );

    lock_status #(
        .hold_cycles (hold_cycles)
    ) i_lock_status (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .relock_on (relock_on),
        .state     (lock_state)
    );

    // Output sum, wraps on overflow
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            signal_out <= '0;
        end else begin
            signal_out <= sweep_val + pi_y;
        end
    end

endmodule

`default_nettype wire
